// File: include/mipsConsts.svh
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// primary opcodes
`define OP_RTYPE 6'h00
`define OP_J 6'h02
`define OP_BEQ 6'h04
`define OP_BNE 6'h05
`define OP_ADDIU 6'h09
`define OP_ORI 6'h0d
`define OP_LUI 6'h0f
`define OP_LW 6'h23
`define OP_SW 6'h2b

// funct field of r-type words
`define FN_SLL 6'h00
`define FN_ADDU 6'h21
`define FN_SUBU 6'h23
`define FN_AND 6'h24
`define FN_OR 6'h25
`define FN_SLT 6'h2a

`define RESET_PC 32'h0000_0000
`define BP_INDEX_BITS 6

`endif

// File: verilog/mipsPkg.sv
package mipsPkg;

	typedef enum logic [3:0] {
		aluAdd = 4'd0,
		aluSub = 4'd1,
		aluAnd = 4'd2,
		aluOr = 4'd3,
		aluSlt = 4'd4,
		aluSll = 4'd5,
		aluLui = 4'd6
	} aluOp;

	// all zero is a bubble
	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic memToReg;
		logic aluSrcImm;
		logic immZero;
		logic regDstRd;
		logic branch;
		logic branchNe;
		logic jump;
		aluOp aluOp;
	} ctrlSig;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] pcPlus4;
		logic predTaken;
		ctrlSig ctrl;
		logic [31:0] rsVal;
		logic [31:0] rtVal;
		logic [31:0] imm;
		logic [4:0] shamt;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] writeReg;
	} idExReg;

	typedef struct packed {
		logic [31:0] pc;
		ctrlSig ctrl;
		logic [31:0] aluResult;
		logic [31:0] storeData;
		logic [4:0] writeReg;
	} exMemReg;

	typedef struct packed {
		logic [31:0] pc;
		logic regWrite;
		logic [4:0] writeReg;
		logic [31:0] result;
	} memWbReg;

	// wishbone classic request side
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [31:0] adr;
		logic [31:0] datW;
	} wbReq;

endpackage

// File: verilog/ctrlDecoder.sv
`timescale 1ns/1ps
`include "mipsConsts.svh"

module ctrlDecoder (
	input logic [31:0] instr,
	output mipsPkg::ctrlSig ctrl
);
	logic [5:0] opcode;
	logic [5:0] funct;

	assign opcode = instr[31:26];
	assign funct = instr[5:0];

	always_comb begin
		ctrl = '0;
		// the zero word would otherwise decode as sll
		if (instr != 32'h0) begin
			case (opcode)
				`OP_RTYPE: begin
					ctrl.regWrite = 1'b1;
					ctrl.regDstRd = 1'b1;
					case (funct)
						`FN_ADDU: ctrl.aluOp = mipsPkg::aluAdd;
						`FN_SUBU: ctrl.aluOp = mipsPkg::aluSub;
						`FN_AND: ctrl.aluOp = mipsPkg::aluAnd;
						`FN_OR: ctrl.aluOp = mipsPkg::aluOr;
						`FN_SLT: ctrl.aluOp = mipsPkg::aluSlt;
						`FN_SLL: ctrl.aluOp = mipsPkg::aluSll;
						default: ctrl.regWrite = 1'b0;
					endcase
				end
				`OP_ADDIU: begin
					ctrl.regWrite = 1'b1;
					ctrl.aluSrcImm = 1'b1;
				end
				`OP_ORI: begin
					ctrl.regWrite = 1'b1;
					ctrl.aluSrcImm = 1'b1;
					ctrl.immZero = 1'b1;
					ctrl.aluOp = mipsPkg::aluOr;
				end
				`OP_LUI: begin
					ctrl.regWrite = 1'b1;
					ctrl.aluSrcImm = 1'b1;
					ctrl.aluOp = mipsPkg::aluLui;
				end
				`OP_LW: begin
					ctrl.regWrite = 1'b1;
					ctrl.memRead = 1'b1;
					ctrl.memToReg = 1'b1;
					ctrl.aluSrcImm = 1'b1;
				end
				`OP_SW: begin
					ctrl.memWrite = 1'b1;
					ctrl.aluSrcImm = 1'b1;
				end
				`OP_BEQ: ctrl.branch = 1'b1;
				`OP_BNE: begin
					ctrl.branch = 1'b1;
					ctrl.branchNe = 1'b1;
				end
				`OP_J: ctrl.jump = 1'b1;
				default: ctrl = '0;
			endcase
		end
	end

endmodule

// File: verilog/aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
	input logic [31:0] opA,
	input logic [31:0] opB,
	input logic [4:0] shamt,
	input mipsPkg::aluOp op,
	output logic [31:0] result
);
	logic lessSigned;

	// signed compare for slt
	assign lessSigned = $signed(opA) < $signed(opB);

	always_comb begin
		case (op)
			mipsPkg::aluAdd: result = opA + opB;
			mipsPkg::aluSub: result = opA - opB;
			mipsPkg::aluAnd: result = opA & opB;
			mipsPkg::aluOr: result = opA | opB;
			mipsPkg::aluSlt: result = {31'b0, lessSigned};
			// sll shifts the rt operand
			mipsPkg::aluSll: result = opB << shamt;
			mipsPkg::aluLui: result = {opB[15:0], 16'h0000};
			default: result = 32'h0;
		endcase
	end

endmodule

// File: verilog/regFile.sv
`timescale 1ns/1ps

module regFile (
	input logic clk,
	input logic rstN,
	input logic we,
	input logic [4:0] wAddr,
	input logic [31:0] wData,
	input logic [4:0] rAddrA,
	input logic [4:0] rAddrB,
	output logic [31:0] rDataA,
	output logic [31:0] rDataB
);
	logic [31:0] regs [32];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= 32'h0;
			end
		end else if (we && wAddr != 5'd0) begin
			regs[wAddr] <= wData;
		end
	end

	// write-through so decode sees the value retiring this cycle
	assign rDataA = (rAddrA == 5'd0) ? 32'h0 :
		(we && wAddr == rAddrA) ? wData : regs[rAddrA];
	assign rDataB = (rAddrB == 5'd0) ? 32'h0 :
		(we && wAddr == rAddrB) ? wData : regs[rAddrB];

endmodule

// File: verilog/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit (
	input logic [4:0] rsD,
	input logic [4:0] rtD,
	input logic [4:0] rsE,
	input logic [4:0] rtE,
	input logic [4:0] writeRegE,
	input logic memReadE,
	input logic [4:0] writeRegM,
	input logic regWriteM,
	input logic [4:0] writeRegW,
	input logic regWriteW,
	input logic jumpD,
	input logic mispredictE,
	input logic dStall,
	output logic [1:0] fwdA,
	output logic [1:0] fwdB,
	output logic stallF,
	output logic stallD,
	output logic flushD,
	output logic flushE,
	output logic freeze
);
	logic loadUse;

	// 2'b10 from memory, 2'b01 from writeback, memory wins
	function automatic logic [1:0] fwdSel(input logic [4:0] src, input logic [4:0] dstM,
		input logic wrM, input logic [4:0] dstW, input logic wrW);
		logic [1:0] sel;
		sel = 2'b00;
		if (src != 5'd0 && wrM && dstM == src) begin
			sel = 2'b10;
		end else if (src != 5'd0 && wrW && dstW == src) begin
			sel = 2'b01;
		end
		return sel;
	endfunction

	assign fwdA = fwdSel(rsE, writeRegM, regWriteM, writeRegW, regWriteW);
	assign fwdB = fwdSel(rtE, writeRegM, regWriteM, writeRegW, regWriteW);

	assign loadUse = memReadE && writeRegE != 5'd0 && (writeRegE == rsD || writeRegE == rtD);

	// a pending bus access holds every stage
	assign freeze = dStall;
	assign stallF = loadUse & ~dStall;
	assign stallD = loadUse & ~dStall;
	assign flushE = (loadUse | mispredictE) & ~dStall;
	// a jump held by a load-use stall redirects one cycle later
	assign flushD = ((jumpD & ~loadUse) | mispredictE) & ~dStall;

endmodule

// File: verilog/branchPredictor.sv
`timescale 1ns/1ps
`include "mipsConsts.svh"

module branchPredictor #(
	parameter int indexBits = `BP_INDEX_BITS
) (
	input logic clk,
	input logic rstN,
	input logic [31:0] pcF,
	output logic predictTaken,
	input logic updateEn,
	input logic [31:0] updatePc,
	input logic actualTaken
);
	localparam int depth = 1 << indexBits;

	logic [1:0] counters [depth];
	logic [indexBits-1:0] readIdx;
	logic [indexBits-1:0] writeIdx;

	// drop the low two bits of the word-aligned pc
	assign readIdx = pcF[indexBits+1:2];
	assign writeIdx = updatePc[indexBits+1:2];
	assign predictTaken = counters[readIdx][1];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < depth; i++) begin
				counters[i] <= 2'b01;
			end
		end else if (updateEn) begin
			// saturate at both ends
			if (actualTaken && counters[writeIdx] != 2'b11) begin
				counters[writeIdx] <= counters[writeIdx] + 2'd1;
			end else if (!actualTaken && counters[writeIdx] != 2'b00) begin
				counters[writeIdx] <= counters[writeIdx] - 2'd1;
			end
		end
	end

endmodule

// File: verilog/datapath.sv
`timescale 1ns/1ps
`include "mipsConsts.svh"

module datapath (
	input logic clk,
	input logic rstN,
	output logic [31:0] pcF,
	input logic [31:0] instrF,
	output mipsPkg::exMemReg memReq,
	input logic [31:0] loadData,
	input logic dStall,
	output logic [31:0] debugWbPc,
	output logic [3:0] debugWbRfWen,
	output logic [4:0] debugWbRfWnum,
	output logic [31:0] debugWbRfWdata
);
	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] pcPlus4;
		logic [31:0] instr;
		logic predTaken;
	} ifIdReg;

	ifIdReg ifId;
	mipsPkg::idExReg idEx;
	mipsPkg::exMemReg exMem;
	mipsPkg::memWbReg memWb;

	logic [31:0] pcPlus4F;
	logic [31:0] predTargetF;
	logic [31:0] nextPc;
	logic predictF;
	logic isBranchF;
	logic predTakenF;
	mipsPkg::ctrlSig ctrlD;
	logic [4:0] rsD;
	logic [4:0] rtD;
	logic [4:0] rdD;
	logic [31:0] rsValD;
	logic [31:0] rtValD;
	logic [31:0] immD;
	logic [31:0] jumpTargetD;
	logic [31:0] srcAE;
	logic [31:0] srcBE;
	logic [31:0] opBE;
	logic [31:0] aluOutE;
	logic [31:0] correctPcE;
	logic takenE;
	logic mispredictE;
	logic [31:0] resultM;
	logic [1:0] fwdA;
	logic [1:0] fwdB;
	logic stallF;
	logic stallD;
	logic flushD;
	logic flushE;
	logic freeze;

	// fetch with a static branch target from the raw word
	assign pcPlus4F = pcF + 32'd4;
	assign isBranchF = instrF[31:26] == `OP_BEQ || instrF[31:26] == `OP_BNE;
	assign predTakenF = isBranchF & predictF;
	assign predTargetF = pcPlus4F + {{14{instrF[15]}}, instrF[15:0], 2'b00};
	assign nextPc = mispredictE ? correctPcE :
		ctrlD.jump ? jumpTargetD :
		predTakenF ? predTargetF : pcPlus4F;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pcF <= `RESET_PC;
		end else if (!freeze && !stallF) begin
			pcF <= nextPc;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			ifId <= '0;
		end else if (!freeze && !stallD) begin
			ifId <= flushD ? '0 : {pcF, pcPlus4F, instrF, predTakenF};
		end
	end

	// decode
	assign rsD = ifId.instr[25:21];
	assign rtD = ifId.instr[20:16];
	assign rdD = ifId.instr[15:11];
	assign immD = ctrlD.immZero ? {16'h0000, ifId.instr[15:0]} :
		{{16{ifId.instr[15]}}, ifId.instr[15:0]};
	assign jumpTargetD = {ifId.pcPlus4[31:28], ifId.instr[25:0], 2'b00};

	ctrlDecoder decoder (.instr(ifId.instr), .ctrl(ctrlD));

	regFile rf (
		.clk(clk),
		.rstN(rstN),
		.we(memWb.regWrite & ~freeze),
		.wAddr(memWb.writeReg),
		.wData(memWb.result),
		.rAddrA(rsD),
		.rAddrB(rtD),
		.rDataA(rsValD),
		.rDataB(rtValD)
	);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			idEx <= '0;
		end else if (!freeze) begin
			if (flushE) begin
				idEx <= '0;
			end else begin
				idEx <= '{pc: ifId.pc, pcPlus4: ifId.pcPlus4, predTaken: ifId.predTaken,
					ctrl: ctrlD, rsVal: rsValD, rtVal: rtValD, imm: immD,
					shamt: ifId.instr[10:6], rs: rsD, rt: rtD,
					writeReg: ctrlD.regDstRd ? rdD : rtD};
			end
		end
	end

	// execute
	always_comb begin
		case (fwdA)
			2'b10: srcAE = exMem.aluResult;
			2'b01: srcAE = memWb.result;
			default: srcAE = idEx.rsVal;
		endcase
		case (fwdB)
			2'b10: srcBE = exMem.aluResult;
			2'b01: srcBE = memWb.result;
			default: srcBE = idEx.rtVal;
		endcase
	end

	assign opBE = idEx.ctrl.aluSrcImm ? idEx.imm : srcBE;

	aluUnit alu (
		.opA(srcAE),
		.opB(opBE),
		.shamt(idEx.shamt),
		.op(idEx.ctrl.aluOp),
		.result(aluOutE)
	);

	// branches compare the forwarded operands, not the alu result
	assign takenE = idEx.ctrl.branch & ((srcAE == srcBE) ^ idEx.ctrl.branchNe);
	assign mispredictE = idEx.ctrl.branch & (takenE != idEx.predTaken);
	assign correctPcE = takenE ? idEx.pcPlus4 + {idEx.imm[29:0], 2'b00} : idEx.pcPlus4;

	branchPredictor predictor (
		.clk(clk),
		.rstN(rstN),
		.pcF(pcF),
		.predictTaken(predictF),
		.updateEn(idEx.ctrl.branch & ~freeze),
		.updatePc(idEx.pc),
		.actualTaken(takenE)
	);

	hazardUnit hazard (
		.rsD(rsD),
		.rtD(rtD),
		.rsE(idEx.rs),
		.rtE(idEx.rt),
		.writeRegE(idEx.writeReg),
		.memReadE(idEx.ctrl.memRead),
		.writeRegM(exMem.writeReg),
		.regWriteM(exMem.ctrl.regWrite),
		.writeRegW(memWb.writeReg),
		.regWriteW(memWb.regWrite),
		.jumpD(ctrlD.jump),
		.mispredictE(mispredictE),
		.dStall(dStall),
		.fwdA(fwdA),
		.fwdB(fwdB),
		.stallF(stallF),
		.stallD(stallD),
		.flushD(flushD),
		.flushE(flushE),
		.freeze(freeze)
	);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			exMem <= '0;
		end else if (!freeze) begin
			exMem <= '{pc: idEx.pc, ctrl: idEx.ctrl, aluResult: aluOutE,
				storeData: srcBE, writeReg: idEx.writeReg};
		end
	end

	// memory
	assign memReq = exMem;
	assign resultM = exMem.ctrl.memToReg ? loadData : exMem.aluResult;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			memWb <= '0;
		end else if (!freeze) begin
			memWb <= '{pc: exMem.pc, regWrite: exMem.ctrl.regWrite,
				writeReg: exMem.writeReg, result: resultM};
		end
	end

	// retirement is reported once, in the cycle the stage advances
	assign debugWbPc = memWb.pc;
	assign debugWbRfWen = {4{memWb.regWrite & ~freeze}};
	assign debugWbRfWnum = memWb.writeReg;
	assign debugWbRfWdata = memWb.result;

	memExclusive: assert property (@(posedge clk) disable iff (!rstN)
		!(exMem.ctrl.memRead && exMem.ctrl.memWrite));

endmodule

// File: verilog/dataBusMaster.sv
`timescale 1ns/1ps

module dataBusMaster (
	input logic clk,
	input logic rstN,
	input mipsPkg::exMemReg memReq,
	output mipsPkg::wbReq wbOut,
	input logic [31:0] wbDatR,
	input logic wbAck,
	output logic [31:0] loadData,
	output logic dStall
);
	logic access;
	logic done;

	assign access = memReq.ctrl.memRead | memReq.ctrl.memWrite;
	// stall until the ack edge, then one free cycle to leave the stage
	assign dStall = access & ~done;

	// request comes from the memory-stage register, frozen while stalled
	assign wbOut.cyc = dStall;
	assign wbOut.stb = dStall;
	assign wbOut.we = dStall & memReq.ctrl.memWrite;
	assign wbOut.adr = memReq.aluResult;
	assign wbOut.datW = memReq.storeData;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			done <= 1'b0;
		end else if (wbOut.stb && wbAck) begin
			done <= 1'b1;
		end else if (!dStall) begin
			done <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (wbOut.stb && wbAck && !wbOut.we) begin
			loadData <= wbDatR;
		end
	end

	reqStable: assert property (@(posedge clk) disable iff (!rstN)
		wbOut.stb && !wbAck |=> wbOut.stb && $stable(wbOut.adr) && $stable(wbOut.we));

endmodule

// File: verilog/mipsCore.sv
`timescale 1ns/1ps

module mipsCore (
	input logic clk,
	input logic rstN,
	output logic [31:0] pcF,
	input logic [31:0] instrF,
	output logic wbCyc,
	output logic wbStb,
	output logic wbWe,
	output logic [31:0] wbAdr,
	output logic [31:0] wbDatW,
	input logic [31:0] wbDatR,
	input logic wbAck,
	output logic [31:0] debugWbPc,
	output logic [3:0] debugWbRfWen,
	output logic [4:0] debugWbRfWnum,
	output logic [31:0] debugWbRfWdata
);
	mipsPkg::exMemReg memReq;
	mipsPkg::wbReq wbOut;
	logic [31:0] loadData;
	logic dStall;

	datapath dp (
		.clk(clk),
		.rstN(rstN),
		.pcF(pcF),
		.instrF(instrF),
		.memReq(memReq),
		.loadData(loadData),
		.dStall(dStall),
		.debugWbPc(debugWbPc),
		.debugWbRfWen(debugWbRfWen),
		.debugWbRfWnum(debugWbRfWnum),
		.debugWbRfWdata(debugWbRfWdata)
	);

	dataBusMaster bus (
		.clk(clk),
		.rstN(rstN),
		.memReq(memReq),
		.wbOut(wbOut),
		.wbDatR(wbDatR),
		.wbAck(wbAck),
		.loadData(loadData),
		.dStall(dStall)
	);

	// wishbone pins
	assign wbCyc = wbOut.cyc;
	assign wbStb = wbOut.stb;
	assign wbWe = wbOut.we;
	assign wbAdr = wbOut.adr;
	assign wbDatW = wbOut.datW;

endmodule

// File: test/tbCore.sv
`timescale 1ns/1ps
`include "mipsConsts.svh"

module tbCore;
	logic clk;
	logic rstN;
	logic [31:0] pcF;
	logic [31:0] instrF;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	logic [31:0] wbAdr;
	logic [31:0] wbDatW;
	logic [31:0] wbDatR;
	logic wbAck;
	logic [31:0] debugWbPc;
	logic [3:0] debugWbRfWen;
	logic [4:0] debugWbRfWnum;
	logic [31:0] debugWbRfWdata;

	logic [31:0] rom [256];
	logic [31:0] mem [256];
	string testName [16];
	int testErr [16];
	bit testDone [16];
	int nTests;
	logic [4:0] wReg [64];
	logic [31:0] wVal [64];
	int wTest [64];
	int wCount;
	int wIdx;
	logic [31:0] mAddr [16];
	logic [31:0] mVal [16];
	int mCount;
	int nInstr;
	int errCount;
	int checkCount;
	int curTest;
	int cycles;
	int limit;
	logic [31:0] lfsr;
	logic inReq;
	logic [1:0] waitLeft;
	logic holdValid;
	logic heldWe;
	logic [31:0] heldAdr;
	logic [31:0] heldDatW;

	mipsCore dut (.*);

	always #10 clk = ~clk;

	assign instrF = rom[pcF[9:2]];

	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// r-type words write rd, immediate words write rt
	function automatic logic [4:0] destReg(input logic [31:0] word);
		return (word[31:26] == `OP_RTYPE) ? word[15:11] : word[20:16];
	endfunction

	task automatic drawWaits(output logic [1:0] w);
		lfsr = lfsrStep(lfsr);
		w[0] = lfsr[0];
		lfsr = lfsrStep(lfsr);
		w[1] = lfsr[0];
	endtask

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		checkCount++;
		if (got !== exp) begin
			$display("ERROR %0s: got %08h expected %08h", name, got, exp);
			errCount++;
			testErr[curTest]++;
		end
	endtask

	task automatic reportTest(input int id);
		$display("test %0s: %0s, %0d errors", testName[id],
			testErr[id] == 0 ? "ok" : "failed", testErr[id]);
		testDone[id] = 1'b1;
	endtask

	// wishbone slave with 0 to 3 random wait states
	always @(posedge clk) begin : slave
		logic [1:0] w;
		if (!rstN) begin
			wbAck <= 1'b0;
			inReq <= 1'b0;
		end else if (wbAck) begin
			wbAck <= 1'b0;
			inReq <= 1'b0;
		end else if (wbCyc && wbStb) begin
			if (!inReq) begin
				drawWaits(w);
				inReq <= 1'b1;
				waitLeft <= w;
			end else if (waitLeft == 2'd0) begin
				wbAck <= 1'b1;
				if (wbWe) begin
					mem[wbAdr[9:2]] <= wbDatW;
				end else begin
					wbDatR <= mem[wbAdr[9:2]];
				end
			end else begin
				waitLeft <= waitLeft - 2'd1;
			end
		end
	end

	// request must hold while waiting for ack
	always @(posedge clk) begin
		if (rstN) begin
			if (holdValid) begin
				checkValue("wbStb", {31'b0, wbStb}, 32'h1);
				checkValue("wbWe", {31'b0, wbWe}, {31'b0, heldWe});
				checkValue("wbAdr", wbAdr, heldAdr);
				checkValue("wbDatW", wbDatW, heldDatW);
			end
			holdValid <= wbStb && !wbAck;
			heldWe <= wbWe;
			heldAdr <= wbAdr;
			heldDatW <= wbDatW;
		end else begin
			holdValid <= 1'b0;
		end
	end

	// retirement in order against the expected writes
	always @(posedge clk) begin
		if (rstN && debugWbRfWen == 4'hF) begin
			if (wIdx >= wCount) begin
				$display("unexpected extra retirement of register %0d at pc %08h",
					debugWbRfWnum, debugWbPc);
				errCount++;
				testErr[curTest]++;
			end else begin
				curTest = wTest[wIdx];
				checkValue("debugWbRfWnum", {27'b0, debugWbRfWnum}, {27'b0, wReg[wIdx]});
				checkValue("debugWbRfWdata", debugWbRfWdata, wVal[wIdx]);
				checkValue("rom[debugWbPc] dest", {27'b0, destReg(rom[debugWbPc[9:2]])},
					{27'b0, wReg[wIdx]});
				if (wIdx + 1 == wCount || wTest[wIdx + 1] != wTest[wIdx]) begin
					reportTest(wTest[wIdx]);
				end
				wIdx++;
				if (wIdx < wCount) begin
					curTest = wTest[wIdx];
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			$display("timeout after %0d cycles, the program did not retire", cycles);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	initial begin : main
		int fd;
		int code;
		int dummy;
		int spins;
		string tag;
		string line;
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] loopPc;
		clk = 1'b0;
		rstN = 1'b0;
		wbDatR = 32'h0;
		wbAck = 1'b0;
		lfsr = 32'h5b8e_76ef;
		limit = 100000;
		loopPc = 32'h0;
		for (int i = 0; i < 256; i++) begin
			rom[i] = 32'h0;
			mem[i] = (i * 32'h0101_0101) ^ 32'ha5a5_a5a5;
		end
		fd = $fopen("test/coreTrace.txt", "r");
		if (fd == 0) begin
			$display("could not open the trace file test/coreTrace.txt");
			$display("RESULT: FAIL");
			$finish;
		end else begin
			code = $fscanf(fd, " %s", tag);
			while (code == 1) begin
				case (tag)
					"#": dummy = $fgets(line, fd);
					"T": begin
						dummy = $fscanf(fd, " %s", line);
						testName[nTests] = line;
						nTests++;
					end
					"I": begin
						dummy = $fscanf(fd, " %h %h", a, d);
						rom[a[9:2]] = d;
						loopPc = a;
						nInstr++;
					end
					"D": begin
						dummy = $fscanf(fd, " %h %h", a, d);
						mem[a[9:2]] = d;
					end
					"W": begin
						dummy = $fscanf(fd, " %h %h", a, d);
						wReg[wCount] = a[4:0];
						wVal[wCount] = d;
						wTest[wCount] = nTests - 1;
						wCount++;
					end
					"M": begin
						dummy = $fscanf(fd, " %h %h", a, d);
						mAddr[mCount] = a;
						mVal[mCount] = d;
						mCount++;
					end
					default: $display("unknown trace tag %0s", tag);
				endcase
				code = $fscanf(fd, " %s", tag);
			end
			$fclose(fd);
			limit = 20 * nInstr + 200;

			// reset test is section 0
			curTest = 0;
			@(posedge clk);
			@(negedge clk);
			checkValue("wbCyc", {31'b0, wbCyc}, 32'h0);
			checkValue("debugWbRfWen", {28'b0, debugWbRfWen}, 32'h0);
			checkValue("pcF", pcF, `RESET_PC);
			@(posedge clk);
			rstN <= 1'b1;
			@(negedge clk);
			checkValue("wbCyc", {31'b0, wbCyc}, 32'h0);
			checkValue("debugWbRfWen", {28'b0, debugWbRfWen}, 32'h0);
			checkValue("pcF", pcF, `RESET_PC);
			reportTest(0);
			if (wCount > 0) begin
				curTest = wTest[0];
			end

			while (wIdx < wCount) begin
				@(posedge clk);
			end
			// the last trace word is the closing loop, let it spin a few times
			spins = 0;
			while (spins < 4) begin
				@(negedge clk);
				if (pcF == loopPc) begin
					spins++;
				end
			end
			curTest = nTests - 1;
			for (int i = 0; i < mCount; i++) begin
				checkValue("mem", mem[mAddr[i][9:2]], mVal[i]);
			end
			for (int i = 0; i < nTests; i++) begin
				if (!testDone[i]) begin
					reportTest(i);
				end
			end
			$display("tests %0d, checks %0d, errors %0d", nTests, checkCount, errCount);
			if (errCount == 0) begin
				$display("RESULT: PASS");
			end else begin
				$display("RESULT: FAIL");
			end
			$finish;
		end
	end

endmodule

// File: build.f
+incdir+include
verilog/mipsPkg.sv
verilog/ctrlDecoder.sv
verilog/aluUnit.sv
verilog/regFile.sv
verilog/hazardUnit.sv
verilog/branchPredictor.sv
verilog/datapath.sv
verilog/dataBusMaster.sv
verilog/mipsCore.sv
test/tbCore.sv

// File: test/coreTrace.txt
# T name | I byteAddr word | D byteAddr word | W reg value (retirement order) | M byteAddr word
# all numbers hex, the first section must be the reset test
T reset
T alu
I 00 24010005
I 04 2402fffd
I 08 00221821
I 0c 00222023
I 10 00222824
I 14 00223025
I 18 0041382a
I 1c 00014100
I 20 3c091234
I 24 3529abcd
W 01 00000005
W 02 fffffffd
W 03 00000002
W 04 00000008
W 05 00000005
W 06 fffffffd
W 07 00000001
W 08 00000050
W 09 12340000
W 09 1234abcd
T loadstore
I 28 240a0100
I 2c 8d4b0000
I 30 016b6021
I 34 ad4c0004
I 38 8d4d0004
I 3c 8d4e0008
I 40 01cd7823
D 100 00000007
D 108 cafef00d
W 0a 00000100
W 0b 00000007
W 0c 0000000e
W 0d 0000000e
W 0e cafef00d
W 0f cafeefff
T branch
I 44 24100000
I 48 24110003
I 4c 26100001
I 50 1611fffe
I 54 12110001
I 58 24120099
I 5c 12000001
I 60 24130055
I 64 0800001b
I 68 24140077
I 6c ad53000c
I 70 24150021
I 74 0800001d
W 10 00000000
W 11 00000003
W 10 00000001
W 10 00000002
W 10 00000003
W 13 00000055
W 15 00000021
T memory
M 100 00000007
M 104 0000000e
M 108 cafef00d
M 10c 00000055
